// File: bench/memSysTb.sv
`timescale 1ns/1ps

module memSysTb
    import memPkg::*;
();

    localparam int FIELDS = 6;
    localparam int MAX_VEC = 64;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_VEC = 20;
    localparam int TAIL_CYCLES = 16;

    localparam logic [31:0] KIND_FETCH = 32'h0;
    localparam logic [31:0] KIND_STORE = 32'h2;
    localparam logic [31:0] END_KIND = 32'hf;

    typedef struct packed {
        logic isData;
        logic checkVal;
        wordT value;
        int   line;
    } expT;

    logic clk;
    logic rst;
    logic rdy;
    logic ioFull;
    logic ifEn;
    addrT ifAddr;
    logic dcEn;
    logic dcStore;
    lenT  dcLen;
    addrT dcAddr;
    wordT dcData;
    logic ifDone;
    wordT ifInst;
    logic dcDone;
    wordT dcDataOut;

    logic [31:0] vecMem [MAX_VEC*FIELDS];
    expT  expQ [$];
    int   vecCount;
    int   errorCount;
    int   issuedCount;
    int   doneCount;
    logic loaded;
    logic stallMode;

    memSys u_dut (
        .clk       (clk),
        .rst       (rst),
        .i_rdy     (rdy),
        .i_ioFull  (ioFull),
        .i_ifEn    (ifEn),
        .i_ifAddr  (ifAddr),
        .i_dcEn    (dcEn),
        .i_dcStore (dcStore),
        .i_dcLen   (dcLen),
        .i_dcAddr  (dcAddr),
        .i_dcData  (dcData),
        .o_ifDone  (ifDone),
        .o_ifInst  (ifInst),
        .o_dcDone  (dcDone),
        .o_dcData  (dcDataOut)
    );

    always #4 clk = ~clk;

    // random stall cycles on both stall inputs
    always @(posedge clk) begin
        #1;
        if (stallMode) begin
            rdy    = ($urandom % 32'd4) != 32'd0;
            ioFull = ($urandom % 32'd5) == 32'd0;
        end else begin
            rdy    = 1'b1;
            ioFull = 1'b0;
        end
    end

    function automatic int countVectors();
        int n;
        n = 0;
        while (n < MAX_VEC && vecMem[n*FIELDS] != END_KIND) begin
            n++;
        end
        return n;
    endfunction

    task automatic driveLine(input int n);
        int base;
        base = n * FIELDS;
        if (vecMem[base] == KIND_FETCH) begin
            ifEn   = 1'b1;
            ifAddr = addrT'(vecMem[base+1]);
        end else begin
            dcEn    = 1'b1;
            dcStore = (vecMem[base] == KIND_STORE);
            dcAddr  = addrT'(vecMem[base+1]);
            dcLen   = lenT'(vecMem[base+2]);
            dcData  = vecMem[base+3];
        end
        issuedCount++;
    endtask

    // only pushes the line if its requester matches wantData
    task automatic queueExpect(input int n, input logic wantData);
        int  base;
        expT e;
        base = n * FIELDS;
        e.isData = (vecMem[base] != KIND_FETCH);
        if (e.isData == wantData) begin
            e.checkVal = (vecMem[base] != KIND_STORE);
            e.value    = vecMem[base+4];
            e.line     = n;
            expQ.push_back(e);
        end
    endtask

    task automatic runVectors();
        int   i;
        logic pairOk;
        i = 0;
        while (i < vecCount) begin
            @(posedge clk);
            #1;
            pairOk = 1'b0;
            if (vecMem[i*FIELDS+5] != 32'h0 && i + 1 < vecCount) begin
                pairOk = (vecMem[i*FIELDS] == KIND_FETCH)
                         != (vecMem[(i+1)*FIELDS] == KIND_FETCH);
                if (!pairOk) begin
                    errorCount++;
                    $display("vector %0d is paired but does not hold one fetch and one data", i);
                end
            end
            // data is served first, so its result is queued first
            queueExpect(i, 1'b1);
            if (pairOk) begin
                queueExpect(i + 1, 1'b1);
            end
            queueExpect(i, 1'b0);
            if (pairOk) begin
                queueExpect(i + 1, 1'b0);
            end
            driveLine(i);
            if (pairOk) begin
                driveLine(i + 1);
                i += 2;
            end else begin
                i += 1;
            end
            @(posedge clk);
            #1;
            ifEn = 1'b0;
            dcEn = 1'b0;
            while (expQ.size() != 0) begin
                @(posedge clk);
            end
        end
    endtask

    // zero every stored byte so the stalled pass depends on its own stores
    task automatic clearStores();
        for (int n = 0; n < vecCount; n++) begin
            if (vecMem[n*FIELDS] == KIND_STORE) begin
                @(posedge clk);
                #1;
                queueExpect(n, 1'b1);
                driveLine(n);
                dcData = '0;
                @(posedge clk);
                #1;
                dcEn = 1'b0;
                while (expQ.size() != 0) begin
                    @(posedge clk);
                end
            end
        end
    endtask

    task automatic checkDone(input logic isData, input wordT value);
        expT e;
        doneCount++;
        if (expQ.size() == 0) begin
            errorCount++;
            $display("%s done pulse arrived with no request outstanding",
                     isData ? "data" : "fetch");
        end else begin
            e = expQ.pop_front();
            if (e.isData != isData) begin
                errorCount++;
                $display("vector %0d expected a %s done but a %s done came", e.line,
                         e.isData ? "data" : "fetch", isData ? "data" : "fetch");
            end else if (e.checkVal && value !== e.value) begin
                errorCount++;
                $display("Mismatch %s vector %0d expected %h actual %h",
                         isData ? "o_dcData" : "o_ifInst", e.line, e.value, value);
            end
        end
    endtask

    // results are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (dcDone) begin
                checkDone(1'b1, dcDataOut);
            end
            if (ifDone) begin
                checkDone(1'b0, ifInst);
            end
        end
    end

    task automatic finishRun();
        $display("errors %0d, requests issued %0d, done pulses %0d",
                 errorCount, issuedCount, doneCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        int limit;
        wait (loaded);
        // plain pass and clearing, then the stalled pass at twice the budget
        limit = vecCount * CYCLES_PER_VEC * 3 + RESET_CYCLES + TAIL_CYCLES;
        repeat (limit) @(posedge clk);
        errorCount++;
        $display("timeout, a done strobe never came within %0d cycles", limit);
        finishRun();
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioFull = 1'b0;
        ifEn = 1'b0;
        ifAddr = '0;
        dcEn = 1'b0;
        dcStore = 1'b0;
        dcLen = '0;
        dcAddr = '0;
        dcData = '0;
        errorCount = 0;
        issuedCount = 0;
        doneCount = 0;
        stallMode = 1'b0;
        loaded = 1'b0;
        void'($urandom(32'h5742_208a));
        $readmemh("bench/memSysVectors.txt", vecMem);
        vecCount = countVectors();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        runVectors();
        clearStores();
        stallMode = 1'b1;
        runVectors();
        stallMode = 1'b0;

        // stray done pulses would show up here
        repeat (TAIL_CYCLES) @(posedge clk);
        if (doneCount != issuedCount) begin
            errorCount++;
            $display("%0d done pulses for %0d issued requests", doneCount, issuedCount);
        end
        finishRun();
    end

endmodule

// File: bench/memSysVectors.txt
// columns: kind address length store_data expected_read pair
// kind 0 fetch, 1 load, 2 store, f end of list; pair 1 issues the line together with the next
// word stores, then fetches
2 0100 4 00500093 00000000 0
2 0104 4 00a00113 00000000 0
2 0108 4 002081b3 00000000 0
2 010c 4 fe3100e3 00000000 0
0 0100 4 00000000 00500093 0
0 0104 4 00000000 00a00113 0
0 0108 4 00000000 002081b3 0
0 010c 4 00000000 fe3100e3 0
// byte and halfword stores merged into a word
2 0200 4 11223344 00000000 0
2 0201 1 000000aa 00000000 0
1 0200 4 00000000 1122aa44 0
2 0202 2 0000beef 00000000 0
1 0200 4 00000000 beefaa44 0
2 0203 1 12345677 00000000 0
1 0200 4 00000000 77efaa44 0
2 0204 4 cafef00d 00000000 0
2 0206 2 99995a5a 00000000 0
1 0204 4 00000000 5a5af00d 0
// short loads are zero-extended
1 0200 1 00000000 00000044 0
1 0201 1 00000000 000000aa 0
1 0203 1 00000000 00000077 0
1 0202 2 00000000 000077ef 0
1 0200 2 00000000 0000aa44 0
1 0205 2 00000000 00005af0 0
1 0207 1 00000000 0000005a 0
1 0201 4 00000000 0d77efaa 0
// never written
1 0300 4 00000000 00000000 0
0 0400 4 00000000 00000000 0
// fetch and data strobed in the same cycle
0 0100 4 00000000 00500093 1
1 0200 4 00000000 77efaa44 0
1 0104 2 00000000 00000113 1
0 0108 4 00000000 002081b3 0
2 0110 4 deadbeef 00000000 1
0 0110 4 00000000 deadbeef 0
1 0110 1 00000000 000000ef 0
0 010c 4 00000000 fe3100e3 1
2 0111 1 000000c3 00000000 0
1 0110 4 00000000 deadc3ef 0
f 0000 0 00000000 00000000 0

// File: build.f
hw/memPkg.sv
hw/ctrlPkg.sv
hw/byteRam.sv
hw/reqHold.sv
hw/memCtrl.sv
hw/memSys.sv
bench/memSysTb.sv

// File: hw/byteRam.sv
`timescale 1ns/1ps

module byteRam
    import memPkg::*;
(
    input  logic clk,
    input  addrT i_addr,
    input  logic i_we,
    input  byteT i_wData,
    output byteT o_rData
);

    byteT mem [RAM_DEPTH];

    // contents start at zero
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wData;
        end
        o_rData <= mem[i_addr];
    end

endmodule

// File: hw/ctrlPkg.sv
package ctrlPkg;

    // controller FSM
    // one state per kind of transfer, IDLE between them
    typedef enum logic [1:0] {
        IDLE,
        RD_INST,
        RD_DATA,
        WR_DATA
    } ctrlStateT;

    // kind of a pending data request
    typedef enum logic {
        LOAD,
        STORE
    } accKindT;

endpackage

// File: hw/memCtrl.sv
`timescale 1ns/1ps

module memCtrl
    import memPkg::*;
    import ctrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // stall inputs
    input  logic    i_rdy,
    input  logic    i_ioFull,

    // pending slots from the holding block
    input  logic    i_ifPend,
    input  addrT    i_ifAddr,
    input  logic    i_dcPend,
    input  accKindT i_dcKind,
    input  lenT     i_dcLen,
    input  addrT    i_dcAddr,
    input  wordT    i_dcData,

    // RAM read data, one cycle after the address
    input  byteT    i_ramRData,

    output logic    o_ifTake,
    output logic    o_dcTake,

    // RAM port
    output addrT    o_ramAddr,
    output logic    o_ramWe,
    output byteT    o_ramWData,

    // results
    output logic    o_ifDone,
    output wordT    o_ifInst,
    output logic    o_dcDone,
    output wordT    o_dcData
);

    ctrlStateT state;
    lenT       stage;
    lenT       prevIdx;
    lenT       ramIdx;
    lenT       lenReg;
    addrT      addrReg;
    wordT      dataReg;
    wordT      asmReg;
    wordT      asmNext;
    logic      stall;
    logic      lastStage;
    logic      isRead;
    logic      acceptDc;
    logic      acceptIf;

    assign stall = !i_rdy || i_ioFull;
    assign isRead = (state == RD_INST) || (state == RD_DATA);

    // data before fetch
    assign acceptDc = (state == IDLE) && !stall && i_dcPend;
    assign acceptIf = (state == IDLE) && !stall && i_ifPend && !i_dcPend;

    assign o_dcTake = acceptDc;
    assign o_ifTake = acceptIf;

    assign prevIdx = stage - 1'b1;

    // while stalled the RAM re-reads the byte that is due next cycle
    assign ramIdx = (stall && stage != '0) ? prevIdx : stage;

    assign o_ramAddr  = addrReg + addrT'(ramIdx);
    assign o_ramWe    = (state == WR_DATA) && !stall;
    assign o_ramWData = byteT'(dataReg >> (BYTE_W * stage[1:0]));

    // reads need one extra stage for the last byte to come back
    always_comb begin
        if (state == WR_DATA) begin
            lastStage = (stage == lenReg - 1'b1);
        end else begin
            lastStage = (stage == lenReg);
        end
    end

    // byte addressed in the previous stage, little-endian position
    always_comb begin
        asmNext = asmReg;
        if (stage != '0) begin
            asmNext[BYTE_W*prevIdx[1:0] +: BYTE_W] = i_ramRData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            stage    <= '0;
            o_ifDone <= 1'b0;
            o_dcDone <= 1'b0;
        end else begin
            o_ifDone <= 1'b0;
            o_dcDone <= 1'b0;
            if (!stall) begin
                case (state)
                    IDLE: begin
                        stage <= '0;
                        if (i_dcPend) begin
                            state <= (i_dcKind == STORE) ? WR_DATA : RD_DATA;
                        end else if (i_ifPend) begin
                            state <= RD_INST;
                        end
                    end
                    RD_INST, RD_DATA, WR_DATA: begin
                        if (lastStage) begin
                            state <= IDLE;
                            stage <= '0;
                            if (state == RD_INST) begin
                                o_ifDone <= 1'b1;
                            end else begin
                                o_dcDone <= 1'b1;
                            end
                        end else begin
                            stage <= stage + 1'b1;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // latched request and assembly register
    always_ff @(posedge clk) begin
        if (acceptDc) begin
            addrReg <= i_dcAddr;
            lenReg  <= i_dcLen;
            dataReg <= i_dcData;
            asmReg  <= '0;
        end else if (acceptIf) begin
            addrReg <= i_ifAddr;
            lenReg  <= lenT'(LEN_WORD);
            asmReg  <= '0;
        end else if (!stall && isRead) begin
            asmReg <= asmNext;
        end

        // upper bytes stay zero on short loads
        if (!stall && lastStage && state == RD_INST) begin
            o_ifInst <= asmNext;
        end
        if (!stall && lastStage && state == RD_DATA) begin
            o_dcData <= asmNext;
        end
    end

    // a frozen stage must never see a write, so each write moves the store on
    a_writeAdvances: assert property (@(posedge clk) disable iff (rst)
        o_ramWe |=> (state == IDLE) || (stage == $past(stage) + 1'b1))
        else $error("RAM write without the store moving to the next byte");

    a_donePulse: assert property (@(posedge clk) disable iff (rst)
        (o_ifDone || o_dcDone) |=> !o_ifDone && !o_dcDone)
        else $error("done strobe held longer than one cycle");

endmodule

// File: hw/memPkg.sv
package memPkg;

    // address space of the byte RAM
    localparam int ADDR_W = 16;
    localparam int RAM_DEPTH = 65536;

    // data path widths
    localparam int BYTE_W = 8;
    localparam int WORD_W = 32;

    // access length field, counted in bytes
    localparam int LEN_W = 3;

    // legal access lengths
    localparam int LEN_BYTE = 1;
    localparam int LEN_HALF = 2;
    localparam int LEN_WORD = 4;

    // byte address
    typedef logic [ADDR_W-1:0] addrT;

    // one RAM data byte
    typedef logic [BYTE_W-1:0] byteT;

    // instruction or data word
    typedef logic [WORD_W-1:0] wordT;

    // access length, also used as the byte stage counter
    typedef logic [LEN_W-1:0] lenT;

endpackage

// File: hw/memSys.sv
`timescale 1ns/1ps

module memSys
    import memPkg::*;
    import ctrlPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,
    input  logic i_ioFull,

    // fetch requester
    input  logic i_ifEn,
    input  addrT i_ifAddr,

    // data requester
    input  logic i_dcEn,
    input  logic i_dcStore,
    input  lenT  i_dcLen,
    input  addrT i_dcAddr,
    input  wordT i_dcData,

    output logic o_ifDone,
    output wordT o_ifInst,
    output logic o_dcDone,
    output wordT o_dcData
);

    logic    ifPend;
    addrT    ifAddr;
    logic    dcPend;
    accKindT dcKind;
    lenT     dcLen;
    addrT    dcAddr;
    wordT    dcData;
    logic    ifTake;
    logic    dcTake;

    addrT    ramAddr;
    logic    ramWe;
    byteT    ramWData;
    byteT    ramRData;

    reqHold u_hold (
        .clk       (clk),
        .rst       (rst),
        .i_ifEn    (i_ifEn),
        .i_ifAddr  (i_ifAddr),
        .i_dcEn    (i_dcEn),
        .i_dcStore (i_dcStore),
        .i_dcLen   (i_dcLen),
        .i_dcAddr  (i_dcAddr),
        .i_dcData  (i_dcData),
        .i_ifTake  (ifTake),
        .i_dcTake  (dcTake),
        .o_ifPend  (ifPend),
        .o_ifAddr  (ifAddr),
        .o_dcPend  (dcPend),
        .o_dcKind  (dcKind),
        .o_dcLen   (dcLen),
        .o_dcAddr  (dcAddr),
        .o_dcData  (dcData)
    );

    memCtrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (i_rdy),
        .i_ioFull   (i_ioFull),
        .i_ifPend   (ifPend),
        .i_ifAddr   (ifAddr),
        .i_dcPend   (dcPend),
        .i_dcKind   (dcKind),
        .i_dcLen    (dcLen),
        .i_dcAddr   (dcAddr),
        .i_dcData   (dcData),
        .i_ramRData (ramRData),
        .o_ifTake   (ifTake),
        .o_dcTake   (dcTake),
        .o_ramAddr  (ramAddr),
        .o_ramWe    (ramWe),
        .o_ramWData (ramWData),
        .o_ifDone   (o_ifDone),
        .o_ifInst   (o_ifInst),
        .o_dcDone   (o_dcDone),
        .o_dcData   (o_dcData)
    );

    byteRam u_ram (
        .clk     (clk),
        .i_addr  (ramAddr),
        .i_we    (ramWe),
        .i_wData (ramWData),
        .o_rData (ramRData)
    );

endmodule

// File: hw/reqHold.sv
`timescale 1ns/1ps

module reqHold
    import memPkg::*;
    import ctrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // fetch strobe
    input  logic    i_ifEn,
    input  addrT    i_ifAddr,

    // data strobe
    input  logic    i_dcEn,
    input  logic    i_dcStore,
    input  lenT     i_dcLen,
    input  addrT    i_dcAddr,
    input  wordT    i_dcData,

    // acceptance from the controller
    input  logic    i_ifTake,
    input  logic    i_dcTake,

    // pending fetch slot
    output logic    o_ifPend,
    output addrT    o_ifAddr,

    // pending data slot
    output logic    o_dcPend,
    output accKindT o_dcKind,
    output lenT     o_dcLen,
    output addrT    o_dcAddr,
    output wordT    o_dcData
);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ifPend <= 1'b0;
            o_dcPend <= 1'b0;
        end else begin
            if (i_ifEn) begin
                o_ifPend <= 1'b1;
            end else if (i_ifTake) begin
                o_ifPend <= 1'b0;
            end

            if (i_dcEn) begin
                o_dcPend <= 1'b1;
            end else if (i_dcTake) begin
                o_dcPend <= 1'b0;
            end
        end
    end

    // fields are only sampled in the strobe cycle
    always_ff @(posedge clk) begin
        if (i_ifEn) begin
            o_ifAddr <= i_ifAddr;
        end
        if (i_dcEn) begin
            o_dcKind <= i_dcStore ? STORE : LOAD;
            o_dcLen  <= i_dcLen;
            o_dcAddr <= i_dcAddr;
            o_dcData <= i_dcData;
        end
    end

    // one outstanding request per requester
    a_ifNoRestrobe: assert property (@(posedge clk) disable iff (rst)
        i_ifEn |-> !o_ifPend)
        else $error("fetch strobe while a fetch is still pending");

    a_dcNoRestrobe: assert property (@(posedge clk) disable iff (rst)
        i_dcEn |-> !o_dcPend)
        else $error("data strobe while a data request is still pending");

    a_dcLenLegal: assert property (@(posedge clk) disable iff (rst)
        i_dcEn |-> (i_dcLen == lenT'(LEN_BYTE) || i_dcLen == lenT'(LEN_HALF)
                    || i_dcLen == lenT'(LEN_WORD)))
        else $error("illegal data access length %0d", i_dcLen);

endmodule

// File: run.sh
#!/bin/sh
# builds and runs the memSys testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module memSysTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VmemSysTb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
